//--- src/jsp_macros.svh
/* Widths and FIFO depth of the JTAG serial port, included by jsp_pkg and the RTL */
`ifndef JSP_MACROS_SVH
`define JSP_MACROS_SVH

// Serial data
`define JSP_BYTE_W     8  // One byte on TDI or TDO

// Counters
`define JSP_CNT_W      4  // FIFO counts 0..8, user counts 0..15

// FIFOs
`define JSP_FIFO_DEPTH 8  // Entries per direction
`define JSP_FIFO_AW    3  // Pointer width, log2 of the depth

`endif

//--- src/jsp_pkg.sv
/* Shared types of the JTAG serial port: data and count vectors, FSM states */
`include "jsp_macros.svh"

package jsp_pkg;

  typedef logic [`JSP_BYTE_W-1:0] byte_t;   // One byte of serial data
  typedef logic [`JSP_CNT_W-1:0]  count_t;  // Byte count, free space or bit count

  // Write side, TDI into the receive FIFO
  typedef enum logic [1:0] {
    WR_IDLE,    // No scan in progress
    WR_WAIT,    // Waiting for the start bit
    WR_COUNTS,  // Shifting in the count byte
    WR_XFER     // Shifting in data bytes
  } wr_state_e;

  // Read side, transmit FIFO out to TDO
  typedef enum logic [1:0] {
    RD_IDLE,    // No scan in progress
    RD_COUNTS,  // Shifting out the status byte
    RD_RDACK,   // First bit of a data byte, pop the FIFO here
    RD_XFER     // Remaining bits of a data byte
  } rd_state_e;

endpackage

//--- src/jsp_biu_if.sv
/* Link between the scan controllers and the FIFO unit.
   Strobes are single-cycle, the push or pop lands on the same tck edge */
`timescale 1ns/1ns

interface jsp_biu_if;
  import jsp_pkg::*;

  byte_t  wr_data;      // Byte assembled from TDI
  logic   wr_strobe;    // Push wr_data into the receive FIFO
  logic   rd_strobe;    // Pop the transmit FIFO head
  byte_t  rd_data;      // Transmit FIFO head, show-ahead
  count_t bytes_avail;  // Bytes waiting in the transmit FIFO
  count_t bytes_free;   // Space left in the receive FIFO

  modport biu (
    input  wr_data, wr_strobe, rd_strobe,
    output rd_data, bytes_avail, bytes_free
  );

  modport writer (
    output wr_data, wr_strobe,
    input  bytes_free
  );

  // Free space is needed too, it forms the low nibble of the status byte
  modport reader (
    output rd_strobe,
    input  rd_data, bytes_avail, bytes_free
  );

endinterface

//--- src/jsp_byte_fifo.sv
/* Show-ahead byte FIFO with occupancy count, one per direction in jsp_biu.
   Pushes into a full FIFO and pops from an empty one are dropped */
`timescale 1ns/1ns
`include "jsp_macros.svh"

module jsp_byte_fifo (
  input  logic            tck_i,
  input  logic            rst_i,
  input  logic            push_i,   // Write data_i at this edge
  input  jsp_pkg::byte_t  data_i,
  input  logic            pop_i,    // Drop the head at this edge
  output jsp_pkg::byte_t  data_o,   // Head entry, valid while count_o != 0
  output jsp_pkg::count_t count_o
);
  import jsp_pkg::*;

  byte_t                   mem_q [`JSP_FIFO_DEPTH];
  logic [`JSP_FIFO_AW-1:0] wr_ptr_q;
  logic [`JSP_FIFO_AW-1:0] rd_ptr_q;
  count_t                  count_q;
  logic                    full;
  logic                    empty;
  logic                    do_push;
  logic                    do_pop;

  assign full    = (count_q == count_t'(`JSP_FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty;

  // Storage, no reset on the payload
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;  // Idle, or push and pop together
      endcase
    end
  end

  assign data_o  = mem_q[rd_ptr_q];  // Show-ahead head
  assign count_o = count_q;

endmodule

//--- src/jsp_biu.sv
/* FIFO unit of the serial port: receive FIFO from JTAG to the target,
   transmit FIFO from the target to JTAG, and the counts the scans report */
`timescale 1ns/1ns
`include "jsp_macros.svh"

module jsp_biu (
  input  logic           tck_i,
  input  logic           rst_i,
  jsp_biu_if.biu         jtag,
  output jsp_pkg::byte_t rx_data_o,   // Receive FIFO head
  output logic           rx_valid_o,  // Receive FIFO not empty
  input  logic           rx_rd_i,     // Target pops rx_data_o
  input  jsp_pkg::byte_t tx_data_i,
  input  logic           tx_wr_i,     // Target pushes tx_data_i
  output logic           tx_full_o
);
  import jsp_pkg::*;

  count_t rx_count;  // Bytes waiting for the target
  count_t tx_count;  // Bytes waiting for the host

  ////////////////////////////////////////////////////////////
  // JTAG to target
  jsp_byte_fifo rx_fifo_inst (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .push_i  (jtag.wr_strobe),
    .data_i  (jtag.wr_data),
    .pop_i   (rx_rd_i),
    .data_o  (rx_data_o),
    .count_o (rx_count)
  );

  ////////////////////////////////////////////////////////////
  // Target to JTAG
  jsp_byte_fifo tx_fifo_inst (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .push_i  (tx_wr_i),
    .data_i  (tx_data_i),
    .pop_i   (jtag.rd_strobe),
    .data_o  (jtag.rd_data),
    .count_o (tx_count)
  );

  assign rx_valid_o       = (rx_count != '0);
  assign tx_full_o        = (tx_count == count_t'(`JSP_FIFO_DEPTH));
  assign jtag.bytes_free  = count_t'(`JSP_FIFO_DEPTH) - rx_count;  // Space as the host sees it
  assign jtag.bytes_avail = tx_count;

endmodule

//--- src/jsp_in_ctrl.sv
/* Write side of a DR scan: optional start bit, count byte, then data bytes
   from TDI pushed into the receive FIFO while space and user count last */
`timescale 1ns/1ns
`include "jsp_macros.svh"

module jsp_in_ctrl #(
  parameter bit MULTI_CHAIN = 1'b1  // 1 = wait for a start bit of 1 on TDI
) (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       tdi_i,
  input  logic       capture_dr_i,
  input  logic       shift_dr_i,
  input  logic       update_dr_i,
  input  logic       module_select_i,
  jsp_biu_if.writer  biu
);
  import jsp_pkg::*;

  wr_state_e                 state_q;
  wr_state_e                 state_d;
  count_t                    bit_cnt_q;        // Bits of the current byte so far
  count_t                    in_word_cnt_q;    // Receive FIFO space left this scan
  count_t                    user_word_cnt_q;  // Bytes the host still intends to send
  logic [`JSP_BYTE_W-2:0]    tdi_hist_q;       // Last 7 TDI bits, oldest in bit 0
  byte_t                     byte_in;
  logic                      bit_cnt_max;
  logic                      bit_cnt_en;
  logic                      bit_cnt_clr;
  logic                      in_cnt_ld;
  logic                      user_cnt_ld;
  logic                      push;

  assign byte_in     = {tdi_i, tdi_hist_q};  // Whole byte on its 8th bit
  assign bit_cnt_max = (bit_cnt_q == count_t'(`JSP_BYTE_W - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) state_q <= WR_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d     = state_q;
    bit_cnt_en  = 1'b0;
    bit_cnt_clr = 1'b0;
    in_cnt_ld   = 1'b0;
    user_cnt_ld = 1'b0;
    push        = 1'b0;
    unique case (state_q)
      WR_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          state_d     = MULTI_CHAIN ? WR_WAIT : WR_COUNTS;
          bit_cnt_clr = 1'b1;
          in_cnt_ld   = 1'b1;  // Snapshot of free space
        end
      end
      WR_WAIT: begin  // Start bit is not data
        if (update_dr_i) state_d = WR_IDLE;
        else if (shift_dr_i && module_select_i && tdi_i) state_d = WR_COUNTS;
      end
      WR_COUNTS: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (shift_dr_i) begin
          bit_cnt_en = 1'b1;
          if (bit_cnt_max) begin
            state_d     = WR_XFER;
            bit_cnt_clr = 1'b1;
            user_cnt_ld = 1'b1;  // Upper nibble of the count byte
          end
        end
      end
      WR_XFER: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (shift_dr_i) begin
          bit_cnt_en = 1'b1;
          if (bit_cnt_max) begin
            bit_cnt_clr = 1'b1;
            // Bytes past either limit are dropped
            push = (in_word_cnt_q != '0) && (user_word_cnt_q != '0);
          end
        end
      end
      default: state_d = WR_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counters and TDI history
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q       <= '0;
      in_word_cnt_q   <= '0;
      user_word_cnt_q <= '0;
    end else begin
      if (bit_cnt_clr)     bit_cnt_q <= '0;
      else if (bit_cnt_en) bit_cnt_q <= bit_cnt_q + count_t'(1);
      if (in_cnt_ld)       in_word_cnt_q <= biu.bytes_free;
      else if (push)       in_word_cnt_q <= in_word_cnt_q - count_t'(1);
      if (user_cnt_ld)     user_word_cnt_q <= byte_in[`JSP_BYTE_W-1 -: `JSP_CNT_W];
      else if (push)       user_word_cnt_q <= user_word_cnt_q - count_t'(1);
    end
  end

  always_ff @(posedge tck_i) begin
    if (shift_dr_i) tdi_hist_q <= byte_in[`JSP_BYTE_W-1:1];  // LSB first, shift down
  end

  assign biu.wr_data   = byte_in;
  assign biu.wr_strobe = push;

endmodule

//--- src/jsp_out_ctrl.sv
/* Read side of a DR scan: status byte {avail, free} on TDO, then the bytes
   that were available at capture, popped from the transmit FIFO one by one */
`timescale 1ns/1ns
`include "jsp_macros.svh"

module jsp_out_ctrl (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       capture_dr_i,
  input  logic       shift_dr_i,
  input  logic       update_dr_i,
  input  logic       module_select_i,
  output logic       module_tdo_o,
  jsp_biu_if.reader  biu
);
  import jsp_pkg::*;

  rd_state_e state_q;
  rd_state_e state_d;
  count_t    bit_cnt_q;         // Bits of the current byte shifted out
  count_t    out_word_cnt_q;    // Bytes still to send this scan
  byte_t     shift_q;           // TDO shift register, bit 0 on the pin
  logic      bit_cnt_max;
  logic      bit_cnt_en;
  logic      bit_cnt_clr;
  logic      out_cnt_ld;
  logic      ld_status;
  logic      ld_data;
  logic      shift_en;
  logic      pop;

  assign bit_cnt_max = (bit_cnt_q == count_t'(`JSP_BYTE_W - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) state_q <= RD_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d     = state_q;
    bit_cnt_en  = 1'b0;
    bit_cnt_clr = 1'b0;
    out_cnt_ld  = 1'b0;
    ld_status   = 1'b0;
    ld_data     = 1'b0;
    shift_en    = 1'b0;
    pop         = 1'b0;
    unique case (state_q)
      RD_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          state_d     = RD_COUNTS;
          bit_cnt_clr = 1'b1;
          out_cnt_ld  = 1'b1;  // Snapshot of available bytes
          ld_status   = 1'b1;
        end
      end
      RD_COUNTS, RD_XFER: begin
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          bit_cnt_en = 1'b1;
          shift_en   = 1'b1;
          if (bit_cnt_max) begin
            state_d     = RD_RDACK;
            bit_cnt_clr = 1'b1;
            ld_data     = (out_word_cnt_q != '0);  // Otherwise zeros follow
          end
        end
      end
      RD_RDACK: begin  // Byte already loaded, release it from the FIFO
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          state_d    = RD_XFER;
          bit_cnt_en = 1'b1;
          shift_en   = 1'b1;
          pop        = (out_word_cnt_q != '0);
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counters and TDO shift register
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q      <= '0;
      out_word_cnt_q <= '0;
      shift_q        <= '0;
    end else begin
      if (bit_cnt_clr)     bit_cnt_q <= '0;
      else if (bit_cnt_en) bit_cnt_q <= bit_cnt_q + count_t'(1);
      if (out_cnt_ld)      out_word_cnt_q <= biu.bytes_avail;
      else if (pop)        out_word_cnt_q <= out_word_cnt_q - count_t'(1);
      if (ld_status)       shift_q <= {biu.bytes_avail, biu.bytes_free};
      else if (ld_data)    shift_q <= biu.rd_data;  // Load wins over the shift
      else if (shift_en)   shift_q <= {1'b0, shift_q[`JSP_BYTE_W-1:1]};
    end
  end

  assign module_tdo_o  = shift_q[0];
  assign biu.rd_strobe = pop;

endmodule

//--- src/jsp_top.sv
/* JTAG serial port top: TAP-side scan controllers and the target-side FIFO unit,
   joined by jsp_biu_if. Everything runs on tck_i */
`timescale 1ns/1ns

module jsp_top #(
  parameter bit MULTI_CHAIN = 1'b1  // Start-bit wait for multi-device chains
) (
  input  logic           tck_i,
  input  logic           rst_i,
  // TAP side
  input  logic           tdi_i,
  input  logic           capture_dr_i,
  input  logic           shift_dr_i,
  input  logic           update_dr_i,
  input  logic           module_select_i,
  output logic           module_tdo_o,
  // Target side
  output jsp_pkg::byte_t rx_data_o,
  output logic           rx_valid_o,
  input  logic           rx_rd_i,
  input  jsp_pkg::byte_t tx_data_i,
  input  logic           tx_wr_i,
  output logic           tx_full_o
);

  jsp_biu_if biu_bus ();  // Strobes, data and counts

  jsp_in_ctrl #(.MULTI_CHAIN(MULTI_CHAIN)) in_ctrl_inst (
    .tck_i, .rst_i, .tdi_i, .capture_dr_i, .shift_dr_i, .update_dr_i,
    .module_select_i,
    .biu (biu_bus.writer)
  );

  jsp_out_ctrl out_ctrl_inst (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i,
    .module_select_i, .module_tdo_o,
    .biu (biu_bus.reader)
  );

  jsp_biu biu_inst (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .jtag       (biu_bus.biu),
    .rx_data_o  (rx_data_o),
    .rx_valid_o (rx_valid_o),
    .rx_rd_i    (rx_rd_i),
    .tx_data_i  (tx_data_i),
    .tx_wr_i    (tx_wr_i),
    .tx_full_o  (tx_full_o)
  );

endmodule

//--- test/tb_clock.sv
/* Free-running TCK for the serial port testbench, 10 ns period by default */
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic tck_o
);

  initial begin
    tck_o = 1'b0;
    forever #(PERIOD_NS / 2) tck_o = ~tck_o;  // Low half first
  end

endmodule

//--- test/jsp_tb.sv
/* Testbench of the JTAG serial port. TAP scans and target strobes run against
   a queue model of both FIFOs with immediate assertions on every response */
`timescale 1ns/1ns

module jsp_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;
  localparam int SCAN_BITS    = 371;  // Shift cycles of all scans below
  localparam int NUM_SCANS    = 13;   // Each adds a capture and an update cycle
  localparam int TARGET_OPS   = 32;   // tx_wr_i pushes and rx_rd_i pops with slack
  localparam int TIMEOUT_NS   =
    (RESET_CYCLES + SCAN_BITS + 2 * NUM_SCANS + TARGET_OPS + 50) * CLK_PERIOD;

  logic       tck;
  logic       rst;
  logic       tdi;
  logic       capture_dr;
  logic       shift_dr;
  logic       update_dr;
  logic       module_select;
  logic       module_tdo;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_rd;
  logic [7:0] tx_data;
  logic       tx_wr;
  logic       tx_full;

  logic       tdi_q[$];      // Bits to shift in from first to last
  logic       tdo_q[$];      // TDO as seen during each shift cycle
  logic       exp_tdo_q[$];  // TDO predicted by the model
  logic [7:0] rx_model[$];   // Receive FIFO contents
  logic [7:0] tx_model[$];   // Transmit FIFO contents
  integer     seed;
  int         checks;
  int         errors;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_inst (.tck_o(tck));

  jsp_top #(.MULTI_CHAIN(1'b1)) jsp_top_inst (
    .tck_i (tck), .rst_i (rst), .tdi_i (tdi), .capture_dr_i (capture_dr),
    .shift_dr_i (shift_dr), .update_dr_i (update_dr), .module_select_i (module_select),
    .module_tdo_o (module_tdo), .rx_data_o (rx_data), .rx_valid_o (rx_valid),
    .rx_rd_i (rx_rd), .tx_data_i (tx_data), .tx_wr_i (tx_wr), .tx_full_o (tx_full)
  );

  task automatic check(input string name, input logic [7:0] expected,
                       input logic [7:0] actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of one selected scan over tdi_q
  task automatic model_scan();
    int         free_n;
    int         avail_n;
    int         user_n;
    int         pos;
    int         b;
    logic [7:0] status;
    logic [7:0] out_b;
    logic [7:0] in_b;
    exp_tdo_q.delete();
    free_n  = 8 - rx_model.size();  // Snapshots at capture
    avail_n = tx_model.size();
    status  = {4'(avail_n), 4'(free_n)};
    out_b   = '0;
    for (pos = 0; pos < tdi_q.size(); pos++) begin
      if (pos < 8) begin
        exp_tdo_q.push_back(status[3'(pos)]);
      end else if (pos / 8 - 1 < avail_n) begin
        if (pos % 8 == 0) out_b = tx_model.pop_front();  // Popped on its first bit
        exp_tdo_q.push_back(out_b[3'(pos)]);
      end else begin
        exp_tdo_q.push_back(1'b0);  // Nothing left to send
      end
    end
    // Write side skips to the first 1 which is the start bit
    pos = 0;
    while (pos < tdi_q.size() && tdi_q[pos] == 1'b0) pos++;
    pos++;
    if (pos + 8 <= tdi_q.size()) begin
      for (b = 0; b < 8; b++) in_b[3'(b)] = tdi_q[pos + b];
      user_n = int'(in_b[7:4]);  // User count in the upper nibble
      pos += 8;
      while (pos + 8 <= tdi_q.size()) begin
        for (b = 0; b < 8; b++) in_b[3'(b)] = tdi_q[pos + b];
        if (user_n > 0 && free_n > 0) begin
          rx_model.push_back(in_b);
          user_n--;
          free_n--;
        end
        pos += 8;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // TAP and target side drivers on the falling edge
  task automatic run_scan(input logic select);
    int i;
    tdo_q.delete();
    module_select = select;
    capture_dr    = 1'b1;
    @(negedge tck);
    capture_dr = 1'b0;
    for (i = 0; i < tdi_q.size(); i++) begin
      shift_dr = 1'b1;
      tdi      = tdi_q[i];
      tdo_q.push_back(module_tdo);  // Registered and stable until the next rising edge
      @(negedge tck);
    end
    shift_dr  = 1'b0;
    tdi       = 1'b0;
    update_dr = 1'b1;
    @(negedge tck);
    update_dr     = 1'b0;
    module_select = 1'b0;
  endtask

  task automatic check_tdo(input string name);
    int         k;
    int         b;
    logic [7:0] exp_b;
    logic [7:0] act_b;
    for (k = 0; k < exp_tdo_q.size(); k += 8) begin
      exp_b = '0;
      act_b = '0;
      for (b = 0; b < 8 && k + b < exp_tdo_q.size(); b++) begin
        exp_b[3'(b)] = exp_tdo_q[k + b];
        act_b[3'(b)] = tdo_q[k + b];
      end
      check($sformatf("%s tdo byte %0d", name, k / 8), exp_b, act_b);
    end
  endtask

  task automatic read_scan(input string name, input int nbits);
    tdi_q.delete();
    repeat (nbits) tdi_q.push_back(1'b0);  // No start bit so the write side stays idle
    model_scan();
    run_scan(1'b1);
    check_tdo(name);
  endtask

  task automatic write_scan(input string name, input logic with_start,
                            input logic [7:0] count_byte, input int nbytes);
    logic [7:0] data_b;
    int         b;
    tdi_q.delete();
    if (with_start) tdi_q.push_back(1'b1);
    for (b = 0; b < 8; b++) tdi_q.push_back(count_byte[3'(b)]);
    repeat (nbytes) begin
      data_b = 8'($random(seed));
      for (b = 0; b < 8; b++) tdi_q.push_back(data_b[3'(b)]);  // LSB first
    end
    model_scan();
    run_scan(1'b1);
    check_tdo(name);
  endtask

  // Well-formed write stream that a selected writer would accept
  task automatic idle_scan(input logic [7:0] data_b);
    logic [23:0] stream;
    int          i;
    stream = {7'h00, data_b, 8'h10, 1'b1};  // Start bit, count of 1 and one byte
    tdi_q.delete();
    for (i = 0; i < 24; i++) tdi_q.push_back(stream[i]);
    run_scan(1'b0);
  endtask

  task automatic push_tx(input logic [7:0] value);
    tx_data = value;
    tx_wr   = 1'b1;
    @(negedge tck);
    tx_wr = 1'b0;
    if (tx_model.size() < 8) tx_model.push_back(value);  // Dropped when full
  endtask

  task automatic drain_rx(input string name);
    while (rx_model.size() > 0) begin
      check({name, " rx_valid"}, 8'h01, 8'(rx_valid));
      check({name, " rx_data"}, rx_model.pop_front(), rx_data);
      rx_rd = 1'b1;
      @(negedge tck);
      rx_rd = 1'b0;
    end
    check({name, " rx empty"}, 8'h00, 8'(rx_valid));
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    seed          = 71;
    checks        = 0;
    errors        = 0;
    rst           = 1'b1;
    tdi           = 1'b0;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b0;
    rx_rd         = 1'b0;
    tx_data       = '0;
    tx_wr         = 1'b0;
    repeat (RESET_CYCLES) @(negedge tck);
    rst = 1'b0;

    // Reset values and the empty status byte
    check("reset tdo", 8'h00, 8'(module_tdo));
    check("reset rx_valid", 8'h00, 8'(rx_valid));
    check("reset tx_full", 8'h00, 8'(tx_full));
    read_scan("reset status", 8);

    // Three bytes into the receive FIFO
    write_scan("write", 1'b1, 8'h30, 3);
    check("write rx_valid", 8'h01, 8'(rx_valid));
    drain_rx("write");

    // Four bytes out then zeros then an empty status
    repeat (4) push_tx(8'($random(seed)));
    read_scan("read", 8 + 32 + 8);
    read_scan("read after", 8);

    // Both FIFOs at their limits
    write_scan("limits write", 1'b1, 8'hc0, 10);
    read_scan("limits rx full", 8);
    drain_rx("limits");
    repeat (9) push_tx(8'($random(seed)));
    check("limits tx_full", 8'h01, 8'(tx_full));
    read_scan("limits read", 8 + 64 + 8);
    check("limits tx drained", 8'h00, 8'(tx_full));

    // Unselected scan and missing start bit leave the FIFOs alone
    write_scan("select setup", 1'b1, 8'h10, 1);
    repeat (2) push_tx(8'($random(seed)));
    idle_scan(8'($random(seed)));
    read_scan("select status", 8);
    read_scan("select tx drain", 24);
    write_scan("select no start", 1'b0, 8'h30, 1);  // First 1 sits inside the count
    read_scan("select final status", 8);
    drain_rx("select");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the test sequence did not finish", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- project.f
+incdir+src
src/jsp_pkg.sv
src/jsp_biu_if.sv
src/jsp_byte_fifo.sv
src/jsp_biu.sv
src/jsp_in_ctrl.sv
src/jsp_out_ctrl.sv
src/jsp_top.sv
test/tb_clock.sv
test/jsp_tb.sv

//--- Makefile
TOP = jsp_tb

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
